//--- verilog/memtest_pkg.sv
//*********************************************************************
// Memory test shared package
// Bus structs, CSR register map and generator constants
//*********************************************************************

package memtest_pkg;

	// Byte address width of the burst bus
	localparam int FML_DEPTH = 14;
	// Word address width and word count of the burst memory
	localparam int FML_WORD_AW = FML_DEPTH - 3;
	localparam int FML_WORDS = 2 ** FML_WORD_AW;

	// Four 64-bit beats per burst, 32 bytes per burst
	localparam int BEATS_PER_BURST = 4;
	localparam int BEAT_W = $clog2(BEATS_PER_BURST);
	localparam int BURST_BYTES = 32;

	// CSR bank select on address bits 13 to 10
	localparam logic [3:0] CSR_BANK = 4'h0;

	// Register indices on address bits 2 to 0
	localparam logic [2:0] REG_BURSTS = 3'd0;
	localparam logic [2:0] REG_ERRORS = 3'd1;
	localparam logic [2:0] REG_ADDRESS = 3'd2;
	localparam logic [2:0] REG_WRITE = 3'd3;

	// Generator seed, must never be zero
	localparam logic [63:0] PRNG_SEED = 64'h9e37_79b9_7f4a_7c15;
	// Right shift Galois mask for x^64+x^63+x^61+x^60+1
	localparam logic [63:0] PRNG_TAPS = 64'hd800_0000_0000_0000;

	// Memory request to acknowledge latency
	localparam int ACK_DELAY = 2;
	localparam int ACK_CNT_W = $clog2(ACK_DELAY + 1);

	// One CSR access
	typedef struct packed {
		logic [13:0] a;
		logic        we;
		logic [31:0] di;
	} csr_req_t;

	// FML master to slave
	typedef struct packed {
		logic [FML_DEPTH-1:0] adr;
		logic                 stb;
		logic                 we;
		logic [7:0]           sel;
		logic [63:0]          dout;
	} fml_req_t;

	// FML slave to master
	typedef struct packed {
		logic        ack;
		logic [63:0] din;
	} fml_rsp_t;

endpackage

//--- verilog/memtest_prng64.sv
//*********************************************************************
// 64-bit pseudo-random generator
// Galois LFSR, one step per enable, seed reload on restart
//*********************************************************************

module memtest_prng64 (
	input  logic        sys_clk,
	input  logic        restart,
	input  logic        step,
	output logic [63:0] value
);

	// Generator state
	logic [63:0] state;
	// Next state after one shift
	logic [63:0] state_next;
	// Bit leaving the register on this step
	logic        out_bit;

	assign out_bit = state[0];

	// Right shift with the taps folded back in when a one drops out
	always_comb begin
		state_next = state >> 1;
		if (out_bit) begin
			state_next = state_next ^ memtest_pkg::PRNG_TAPS;
		end
	end

	// Restart takes priority over a step
	always_ff @(posedge sys_clk) begin
		if (restart) begin
			state <= memtest_pkg::PRNG_SEED;
		end else if (step) begin
			state <= state_next;
		end
	end

	// Current state is the output
	// First beat after restart sees the seed itself
	assign value = state;

endmodule

//--- verilog/memtest.sv
//*********************************************************************
// Memory test engine
// CSR bank plus burst sequencer, writes random bursts or checks
// read bursts against the restarted generator
//*********************************************************************

module memtest (
	input  logic                  sys_clk,
	input  logic                  sys_rst,
	input  memtest_pkg::csr_req_t csr_req,
	output logic [31:0]           csr_do,
	output memtest_pkg::fml_req_t fml_req,
	input  memtest_pkg::fml_rsp_t fml_rsp
);

	// CSR decode
	logic csr_sel;
	logic wr_bursts;
	logic wr_errors;
	logic wr_address;
	logic wr_write;

	// Sequencer state
	logic [31:0]                       remaining;
	logic [memtest_pkg::FML_DEPTH-1:0] adr;
	logic                              stb;
	logic                              write_mode;
	logic [memtest_pkg::BEAT_W-1:0]    beat_cnt;

	// Generator hookup
	logic        prng_restart;
	logic        prng_step;
	logic [63:0] prng_value;

	// Read check pipeline
	logic        nomatch;
	logic        step_d;
	logic [31:0] errcount;

	assign csr_sel = csr_req.a[13:10] == memtest_pkg::CSR_BANK;
	assign wr_bursts = csr_sel & csr_req.we & (csr_req.a[2:0] == memtest_pkg::REG_BURSTS);
	assign wr_errors = csr_sel & csr_req.we & (csr_req.a[2:0] == memtest_pkg::REG_ERRORS);
	assign wr_address = csr_sel & csr_req.we & (csr_req.a[2:0] == memtest_pkg::REG_ADDRESS);
	assign wr_write = csr_sel & csr_req.we & (csr_req.a[2:0] == memtest_pkg::REG_WRITE);

	// Starting a pass rewinds the generator on the same edge as stb rises
	assign prng_restart = wr_bursts;

	memtest_prng64 prng_i (
		.sys_clk (sys_clk),
		.restart (prng_restart),
		.step    (prng_step),
		.value   (prng_value)
	);

	// Burst count and strobe
	// Zero count loads but leaves stb low
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			remaining <= '0;
			stb <= 1'b0;
		end else if (wr_bursts) begin
			remaining <= csr_req.di;
			stb <= csr_req.di != 32'd0;
		end else if (fml_rsp.ack) begin
			remaining <= remaining - 32'd1;
			// Last burst acked, drop the request
			if (remaining == 32'd1) begin
				stb <= 1'b0;
			end
		end
	end

	// Burst address, steps one burst per ack and wraps at memory size
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			adr <= '0;
		end else if (wr_address) begin
			adr <= csr_req.di[memtest_pkg::FML_DEPTH-1:0];
		end else if (fml_rsp.ack) begin
			adr <= adr + memtest_pkg::FML_DEPTH'(memtest_pkg::BURST_BYTES);
		end
	end

	// Write or read pass select
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			write_mode <= 1'b0;
		end else if (wr_write) begin
			write_mode <= csr_req.di[0];
		end
	end

	// Trailing beat counter, ack is beat one
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			beat_cnt <= '0;
		end else if (fml_rsp.ack) begin
			beat_cnt <= memtest_pkg::BEAT_W'(memtest_pkg::BEATS_PER_BURST - 1);
		end else if (beat_cnt != '0) begin
			beat_cnt <= beat_cnt - 1'b1;
		end
	end

	// One generator step per data beat
	assign prng_step = fml_rsp.ack | (beat_cnt != '0);

	// Compare stage, only read passes can mismatch
	always_ff @(posedge sys_clk) begin
		nomatch <= (fml_rsp.din != prng_value) & ~write_mode;
	end

	// Error counter lands two cycles after the beat
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			step_d <= 1'b0;
			errcount <= '0;
		end else begin
			step_d <= prng_step;
			if (wr_errors) begin
				errcount <= '0;
			end else if (step_d & nomatch) begin
				errcount <= errcount + 32'd1;
			end
		end
	end

	// Registered read data, zero when another bank is addressed
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_do <= '0;
		end else begin
			csr_do <= '0;
			if (csr_sel) begin
				case (csr_req.a[2:0])
					memtest_pkg::REG_BURSTS: csr_do <= remaining;
					memtest_pkg::REG_ERRORS: csr_do <= errcount;
					memtest_pkg::REG_ADDRESS: csr_do <= 32'(adr);
					memtest_pkg::REG_WRITE: csr_do <= {31'd0, write_mode};
					default: csr_do <= '0;
				endcase
			end
		end
	end

	// Master side of the burst bus, full byte mask only
	always_comb begin
		fml_req.adr = adr;
		fml_req.stb = stb;
		fml_req.we = write_mode;
		fml_req.sel = 8'hff;
		fml_req.dout = prng_value;
	end

endmodule

//--- verilog/fml_bram.sv
//*********************************************************************
// FML burst memory
// On-chip 64-bit word array, acks a request after a fixed delay and
// moves four beats per burst
//*********************************************************************

module fml_bram (
	input  logic                  sys_clk,
	input  logic                  sys_rst,
	input  memtest_pkg::fml_req_t fml_req,
	output memtest_pkg::fml_rsp_t fml_rsp
);

	// Word storage, contents survive reset
	logic [63:0] mem [memtest_pkg::FML_WORDS];

	// Request delay counter, saturates at ACK_DELAY
	logic [memtest_pkg::ACK_CNT_W-1:0] dly;
	// Beat index, zero when no trailing beat runs
	logic [memtest_pkg::BEAT_W-1:0]    beat;
	// Burst word base and direction held for the trailing beats
	logic [memtest_pkg::FML_WORD_AW-1:0] base_word;
	logic                                burst_we;

	logic                                ack;
	logic                                beat_active;
	logic [memtest_pkg::FML_WORD_AW-1:0] widx;
	logic                                wr_en;

	// Ack once the delay ran out and the previous burst finished
	assign ack = fml_req.stb
		& (dly == memtest_pkg::ACK_CNT_W'(memtest_pkg::ACK_DELAY))
		& (beat == '0);

	// Trailing beats two to four
	assign beat_active = beat != '0;

	// Delay counting overlaps the beats of the previous burst
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			dly <= '0;
		end else if (ack | ~fml_req.stb) begin
			dly <= '0;
		end else if (dly != memtest_pkg::ACK_CNT_W'(memtest_pkg::ACK_DELAY)) begin
			dly <= dly + 1'b1;
		end
	end

	// Beat sequencer, wraps back to zero after the last beat
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			beat <= '0;
		end else if (ack) begin
			beat <= memtest_pkg::BEAT_W'(1);
		end else if (beat_active) begin
			beat <= beat + 1'b1;
		end
	end

	// Master moves on after ack, so latch what the beats still need
	always_ff @(posedge sys_clk) begin
		if (ack) begin
			base_word <= fml_req.adr[memtest_pkg::FML_DEPTH-1:3];
			burst_we <= fml_req.we;
		end
	end

	// Beat address is burst address plus 8 bytes per beat
	always_comb begin
		if (ack) begin
			widx = fml_req.adr[memtest_pkg::FML_DEPTH-1:3];
		end else begin
			widx = base_word + memtest_pkg::FML_WORD_AW'(beat);
		end
	end

	assign wr_en = ack ? fml_req.we : (beat_active & burst_we);

	// Store master data on write beats
	always_ff @(posedge sys_clk) begin
		if (wr_en) begin
			mem[widx] <= fml_req.dout;
		end
	end

	// Read data straight from the array, valid in the ack cycle
	assign fml_rsp.ack = ack;
	assign fml_rsp.din = mem[widx];

endmodule

//--- verilog/memtest_top.sv
//*********************************************************************
// Memory test subsystem
// Test engine driving the on-chip burst memory
//*********************************************************************

module memtest_top (
	input  logic                  sys_clk,
	input  logic                  sys_rst,
	input  memtest_pkg::csr_req_t csr_req,
	output logic [31:0]           csr_do
);

	// Burst bus between engine and memory
	memtest_pkg::fml_req_t fml_req;
	memtest_pkg::fml_rsp_t fml_rsp;

	// Burst producer with the register bank
	memtest memtest_i (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.csr_req (csr_req),
		.csr_do  (csr_do),
		.fml_req (fml_req),
		.fml_rsp (fml_rsp)
	);

	// Burst consumer
	fml_bram fml_bram_i (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.fml_req (fml_req),
		.fml_rsp (fml_rsp)
	);

endmodule

//--- tests/memtest_tb_model.svh
//*********************************************************************
// Memory test reference model
// Generator replica and memory image, predicts read pass error counts
//*********************************************************************

`ifndef MEMTEST_TB_MODEL_SVH
`define MEMTEST_TB_MODEL_SVH

// Memory size in bytes and in 64-bit words
localparam int MEM_BYTES = 2 ** memtest_pkg::FML_DEPTH;
localparam int MEM_WORDS = MEM_BYTES / 8;

// Expected memory contents
logic [63:0] image [MEM_WORDS];
// Set once a write pass has stored the word
bit          image_valid [MEM_WORDS];
// Replica of the generator state
logic [63:0] lfsr;

// Every pass starts from the seed
function automatic void restart_lfsr();
	lfsr = memtest_pkg::PRNG_SEED;
endfunction

// Current beat value, then one right shift Galois step
function automatic logic [63:0] next_beat();
	logic [63:0] value;
	value = lfsr;
	lfsr = lfsr >> 1;
	if (value[0]) begin
		lfsr = lfsr ^ memtest_pkg::PRNG_TAPS;
	end
	return value;
endfunction

// Word index of beat i in a pass from byte address addr, wraps at the top
function automatic int beat_word(input int addr, input int i);
	return (addr / 8 + i) % MEM_WORDS;
endfunction

// Record what a write pass of n bursts leaves in memory
function automatic void store_write_pass(input int addr, input int n);
	int idx;
	int i;
	restart_lfsr();
	for (i = 0; i < n * memtest_pkg::BEATS_PER_BURST; i++) begin
		idx = beat_word(addr, i);
		image[idx] = next_beat();
		image_valid[idx] = 1'b1;
	end
endfunction

// Mismatching or never written beats of a read pass
function automatic int predict_errors(input int addr, input int n);
	int          idx;
	int          i;
	int          count;
	logic [63:0] expected;
	restart_lfsr();
	count = 0;
	for (i = 0; i < n * memtest_pkg::BEATS_PER_BURST; i++) begin
		idx = beat_word(addr, i);
		expected = next_beat();
		if (!image_valid[idx] || image[idx] !== expected) begin
			count++;
		end
	end
	return count;
endfunction

// Address register after n bursts, modulo the memory size
function automatic logic [31:0] end_address(input int addr, input int n);
	return 32'((addr + memtest_pkg::BURST_BYTES * n) % MEM_BYTES);
endfunction

`endif

//--- tests/memtest_tb.sv
//*********************************************************************
// Memory test subsystem testbench
// Random write and read passes over the CSR bus, checked against a model
//*********************************************************************

module memtest_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 8;
	localparam int DRIVE_DLY = 2;
	localparam int MAX_BURSTS = 32;
	localparam int AW = memtest_pkg::FML_DEPTH;

	logic                  sys_clk;
	logic                  sys_rst;
	memtest_pkg::csr_req_t csr_req;
	logic [31:0]           csr_do;

	integer seed;
	int     checks;
	int     errors;
	longint total_bursts;
	bit     plan_ready;

	// Randomly drawn test parameters
	logic [AW-1:0] addr_a;
	logic [AW-1:0] addr_c;
	logic [AW-1:0] addr_d;
	int            count_a;
	int            count_c;
	int            count_d;
	int            offset_c;
	logic [3:0]    other_bank;

	`include "memtest_tb_model.svh"

	memtest_top memtest_top_i (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.csr_req (csr_req),
		.csr_do  (csr_do)
	);

	always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

	function automatic int random_below(input int n);
		logic [31:0] r;
		r = $random(seed);
		return int'(r % 32'(n));
	endfunction

	function automatic int random_count(input int lo);
		return lo + random_below(MAX_BURSTS - lo + 1);
	endfunction

	// Burst aligned start address
	function automatic logic [AW-1:0] random_addr();
		logic [31:0] r;
		r = $random(seed);
		return r[AW-1:0] & ~AW'(memtest_pkg::BURST_BYTES - 1);
	endfunction

	// One CSR write that takes effect on the second edge
	task automatic csr_write(input logic [2:0] idx, input logic [31:0] value);
		@(posedge sys_clk);
		#DRIVE_DLY;
		csr_req.a = {memtest_pkg::CSR_BANK, 7'd0, idx};
		csr_req.we = 1'b1;
		csr_req.di = value;
		@(posedge sys_clk);
		#DRIVE_DLY;
		csr_req.we = 1'b0;
	endtask

	// Registered read with data sampled just after the edge that loads it
	task automatic csr_read(input logic [3:0] bank, input logic [2:0] idx,
		output logic [31:0] value);
		@(posedge sys_clk);
		#DRIVE_DLY;
		csr_req.a = {bank, 7'd0, idx};
		csr_req.we = 1'b0;
		@(posedge sys_clk);
		#DRIVE_DLY;
		value = csr_do;
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("** Error at %0d ns: %s expected 0x%08h, got 0x%08h",
				$time, name, expected, actual);
		end
	endtask

	task automatic expect_reg(input logic [3:0] bank, input logic [2:0] idx,
		input string name, input logic [31:0] expected);
		logic [31:0] value;
		csr_read(bank, idx, value);
		check_value(name, expected, value);
	endtask

	// Remaining count must stay within the load and never rise
	task automatic wait_idle(input int n);
		logic [31:0] value;
		logic [31:0] last;
		int          polls;
		int          limit;
		value = 32'(n);
		last = 32'(n);
		polls = 0;
		// Room for two polls per burst plus the ack latency
		limit = 4 * n + 16;
		while (value != 0 && polls < limit) begin
			csr_read(memtest_pkg::CSR_BANK, memtest_pkg::REG_BURSTS, value);
			polls++;
			checks++;
			assert (value <= last) else begin
				errors++;
				$display("** Error at %0d ns: REG_BURSTS expected at most %0d, got %0d",
					$time, last, value);
			end
			last = value;
		end
		checks++;
		assert (value == 0) else begin
			errors++;
			$display("Pass of %0d bursts still running after %0d polls", n, polls);
		end
	endtask

	// Full pass that sets up, starts, waits and then checks the end state
	task automatic run_pass(input logic [AW-1:0] addr, input int n, input bit write);
		csr_write(memtest_pkg::REG_ADDRESS, 32'(addr));
		csr_write(memtest_pkg::REG_WRITE, {31'd0, write});
		csr_write(memtest_pkg::REG_BURSTS, 32'(n));
		if (write) begin
			store_write_pass(int'(addr), n);
		end
		wait_idle(n);
		// Three trailing beats plus the two cycle compare
		repeat (memtest_pkg::BEATS_PER_BURST + 2) @(posedge sys_clk);
		expect_reg(memtest_pkg::CSR_BANK, memtest_pkg::REG_BURSTS, "REG_BURSTS", 32'd0);
		expect_reg(memtest_pkg::CSR_BANK, memtest_pkg::REG_ADDRESS, "REG_ADDRESS",
			end_address(int'(addr), n));
	endtask

	// Watchdog sized from the total burst count
	initial begin
		longint limit_ns;
		wait (plan_ready);
		limit_ns = total_bursts * 8 * CLK_PERIOD + 200_000;
		#(limit_ns);
		$display("Watchdog expired after %0d ns, run did not finish", limit_ns);
		$display("Regression failed");
		$finish;
	end

	initial begin
		logic [31:0] err_expected;
		int          i;
		sys_clk = 1'b0;
		sys_rst = 1'b1;
		csr_req = '0;
		seed = 32'h3dbf;
		checks = 0;
		errors = 0;
		plan_ready = 1'b0;

		// All random choices and the run length they imply
		addr_a = random_addr();
		count_a = random_count(1);
		addr_c = random_addr();
		count_c = random_count(2);
		offset_c = 1 + random_below(count_c - 1);
		count_d = random_count(1);
		addr_d = addr_c + AW'(memtest_pkg::BURST_BYTES * offset_c);
		other_bank = memtest_pkg::CSR_BANK ^ 4'(1 + random_below(15));
		total_bursts = 2 * count_a + 3 * count_c + count_d;
		plan_ready = 1'b1;

		repeat (RESET_CYCLES) @(posedge sys_clk);
		#DRIVE_DLY;
		sys_rst = 1'b0;

		// Reset state of the own bank
		expect_reg(memtest_pkg::CSR_BANK, memtest_pkg::REG_BURSTS, "REG_BURSTS", 32'd0);
		expect_reg(memtest_pkg::CSR_BANK, memtest_pkg::REG_ERRORS, "REG_ERRORS", 32'd0);
		expect_reg(memtest_pkg::CSR_BANK, memtest_pkg::REG_ADDRESS, "REG_ADDRESS", 32'd0);
		expect_reg(memtest_pkg::CSR_BANK, memtest_pkg::REG_WRITE, "REG_WRITE", 32'd0);

		// Write then read back the same region
		run_pass(addr_a, count_a, 1'b1);
		run_pass(addr_a, count_a, 1'b0);
		expect_reg(memtest_pkg::CSR_BANK, memtest_pkg::REG_ERRORS, "REG_ERRORS",
			32'(predict_errors(int'(addr_a), count_a)));
		expect_reg(other_bank, memtest_pkg::REG_ADDRESS, "csr_do (foreign bank)", 32'd0);

		// Partial overwrite from an offset and a read of the first region
		run_pass(addr_c, count_c, 1'b1);
		run_pass(addr_d, count_d, 1'b1);
		csr_write(memtest_pkg::REG_ERRORS, 32'd0);
		run_pass(addr_c, count_c, 1'b0);
		err_expected = 32'(predict_errors(int'(addr_c), count_c));
		expect_reg(memtest_pkg::CSR_BANK, memtest_pkg::REG_ERRORS, "REG_ERRORS",
			err_expected);

		// Second read adds on top of the first
		run_pass(addr_c, count_c, 1'b0);
		expect_reg(memtest_pkg::CSR_BANK, memtest_pkg::REG_ERRORS, "REG_ERRORS",
			2 * err_expected);

		// Foreign bank reads while the error count is nonzero
		for (i = 0; i < 4; i++) begin
			expect_reg(other_bank, 3'(i), "csr_do (foreign bank)", 32'd0);
		end

		// A write to the error register clears it
		csr_write(memtest_pkg::REG_ERRORS, 32'd0);
		expect_reg(memtest_pkg::CSR_BANK, memtest_pkg::REG_ERRORS, "REG_ERRORS", 32'd0);

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

//--- memtest.f
+incdir+tests
verilog/memtest_pkg.sv
verilog/memtest_prng64.sv
verilog/memtest.sv
verilog/fml_bram.sv
verilog/memtest_top.sv
tests/memtest_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the memory test regression with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module memtest_tb -f memtest.f -o memtest_sim

output=$(./obj_dir/memtest_sim)
echo "$output"

if echo "$output" | grep -qx "Regression passed"; then
	exit 0
fi
exit 1
